// File: include/exec_consts.svh
// Execute stage constants
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath and address width
`define EXEC_DATA_W 32

// Immediate or shift-control field of the instruction
`define EXEC_IMM_W 12

// Branch offset field, in words
`define EXEC_OFFSET_W 24

// Offset is scaled to bytes before the add
`define EXEC_TARGET_SHIFT 2

// Issue to result, in clock cycles
`define EXEC_LATENCY 2

`endif

// File: hw/exec_pkg.sv
// Execute stage types
`include "exec_consts.svh"

package exec_pkg;

  // ALU opcodes, same encoding as the decoded alu_op field
  typedef enum logic [3:0] {
    op_and = 4'd0,
    op_or  = 4'd1,
    op_sub = 4'd2,
    op_add = 4'd3
  } alu_op_e;

  typedef enum logic [1:0] {
    am_rot_imm   = 2'b00, // Rotated 8-bit immediate
    am_reg       = 2'b01,
    am_zext_imm  = 2'b10,
    am_shift_reg = 2'b11  // Rm shifted by an immediate amount
  } addr_mode_e;

  typedef enum logic [1:0] {
    sh_lsl = 2'b00,
    sh_lsr = 2'b01,
    sh_asr = 2'b10,
    sh_ror = 2'b11
  } shift_e;

  // ARM condition field, 1111 is left undefined and never taken
  typedef enum logic [3:0] {
    cond_eq = 4'd0,
    cond_ne = 4'd1,
    cond_cs = 4'd2,
    cond_cc = 4'd3,
    cond_mi = 4'd4,
    cond_pl = 4'd5,
    cond_vs = 4'd6,
    cond_vc = 4'd7,
    cond_hi = 4'd8,
    cond_ls = 4'd9,
    cond_ge = 4'd10,
    cond_lt = 4'd11,
    cond_gt = 4'd12,
    cond_le = 4'd13,
    cond_al = 4'd14
  } cond_e;

  typedef enum logic [1:0] {
    kind_alu = 2'd0,
    kind_b   = 2'd1,
    kind_bl  = 2'd2
  } instr_kind_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic                    taken;
    logic                    link;
    logic [`EXEC_DATA_W-1:0] target;
  } branch_t;

endpackage

// File: hw/exec_result_if.sv
// Operand path result bundle
`timescale 1ns/1ps
`include "exec_consts.svh"

interface exec_result_if
  import exec_pkg::*;
();

  logic                    valid;    // One-cycle strobe
  logic [`EXEC_DATA_W-1:0] result;
  flags_t                  flags;
  logic                    store_cc; // Flags are to be committed

  modport producer (output valid, output result, output flags, output store_cc);

  modport consumer (input valid, input result, input flags, input store_cc);

endinterface

// File: hw/operand_alu.sv
// Operand shifter and ALU
`timescale 1ns/1ps
`include "exec_consts.svh"

module operand_alu
  import exec_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    valid,
  input  alu_op_e                 alu_op,
  input  addr_mode_e              am,
  input  logic [`EXEC_IMM_W-1:0]  imm,
  input  logic [`EXEC_DATA_W-1:0] rm,
  input  logic [`EXEC_DATA_W-1:0] rn,
  input  logic                    store_cc,
  exec_result_if.producer         res
);

  localparam int sh_w = $clog2(`EXEC_DATA_W);
  localparam int msb  = `EXEC_DATA_W - 1;

  logic [`EXEC_DATA_W-1:0] op_b;
  logic [`EXEC_DATA_W-1:0] alu_y;
  logic [`EXEC_DATA_W:0]   sum_ext;
  flags_t                  alu_flags;
  logic [sh_w-1:0]         sh_amt;
  shift_e                  sh_type;

  logic                    valid_q;
  logic [`EXEC_DATA_W-1:0] result_q;
  flags_t                  flags_q;
  logic                    store_cc_q;

  function automatic logic [`EXEC_DATA_W-1:0] ror(input logic [`EXEC_DATA_W-1:0] value,
                                                  input logic [sh_w-1:0]         amt);
    logic [2*`EXEC_DATA_W-1:0] doubled;
    doubled = {value, value} >> amt; // Wrapped bits fall in from the upper copy
    return doubled[`EXEC_DATA_W-1:0];
  endfunction

  assign sh_amt  = imm[11:7];
  assign sh_type = shift_e'(imm[6:5]);

  // Second operand
  always_comb begin
    op_b = '0;
    case (am)
      am_rot_imm:  op_b = ror({{(`EXEC_DATA_W-8){1'b0}}, imm[7:0]}, {imm[11:8], 1'b0});
      am_reg:      op_b = rm;
      am_zext_imm: op_b = {{(`EXEC_DATA_W-`EXEC_IMM_W){1'b0}}, imm};
      am_shift_reg: begin
        case (sh_type)
          sh_lsl: op_b = rm << sh_amt;
          sh_lsr: op_b = rm >> sh_amt;
          sh_asr: op_b = $signed(rm) >>> sh_amt;
          sh_ror: op_b = ror(rm, sh_amt);
          default: op_b = '0;
        endcase
      end
      default: op_b = '0;
    endcase
  end

  assign sum_ext = {1'b0, rn} + {1'b0, op_b};

  always_comb begin
    alu_y       = '0;
    alu_flags.c = 1'b0; // Logic ops leave c and v clear
    alu_flags.v = 1'b0;
    case (alu_op)
      op_and: alu_y = rn & op_b;
      op_or:  alu_y = rn | op_b;
      op_sub: begin
        alu_y       = rn - op_b;
        alu_flags.c = (rn >= op_b); // No borrow
        alu_flags.v = (rn[msb] != op_b[msb]) && (alu_y[msb] != rn[msb]);
      end
      op_add: begin
        {alu_flags.c, alu_y} = sum_ext;
        alu_flags.v = (rn[msb] == op_b[msb]) && (alu_y[msb] != rn[msb]);
      end
      default: alu_y = '0; // Unknown opcode
    endcase
    alu_flags.n = alu_y[msb];
    alu_flags.z = (alu_y == '0);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid;
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      result_q   <= alu_y;
      flags_q    <= alu_flags;
      store_cc_q <= store_cc;
    end
  end

  assign res.valid    = valid_q;
  assign res.result   = result_q;
  assign res.flags    = flags_q;
  assign res.store_cc = store_cc_q;

endmodule

// File: hw/branch_resolver.sv
// Condition check and branch target
`timescale 1ns/1ps
`include "exec_consts.svh"

module branch_resolver
  import exec_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  instr_kind_e                kind,
  input  cond_e                      cond,
  input  logic [`EXEC_OFFSET_W-1:0]  offset,
  input  logic [`EXEC_DATA_W-1:0]    next_pc,
  input  flags_t                     flags_view,
  output branch_t                    br,
  output logic [`EXEC_DATA_W-1:0]    link_pc
);

  logic                    cond_ok;
  logic                    is_branch;
  logic [`EXEC_DATA_W-1:0] offset_sx;
  logic [`EXEC_DATA_W-1:0] target;

  logic                    taken_q;
  logic                    link_q;
  logic [`EXEC_DATA_W-1:0] target_q;
  logic [`EXEC_DATA_W-1:0] link_pc_q;

  function automatic logic cond_true(input cond_e c, input flags_t f);
    case (c)
      cond_eq: return f.z;
      cond_ne: return !f.z;
      cond_cs: return f.c;
      cond_cc: return !f.c;
      cond_mi: return f.n;
      cond_pl: return !f.n;
      cond_vs: return f.v;
      cond_vc: return !f.v;
      cond_hi: return f.c && !f.z;
      cond_ls: return !f.c || f.z;
      cond_ge: return f.n == f.v;
      cond_lt: return f.n != f.v;
      cond_gt: return !f.z && (f.n == f.v);
      cond_le: return f.z || (f.n != f.v);
      cond_al: return 1'b1;
      default: return 1'b0; // 1111 never taken
    endcase
  endfunction

  assign cond_ok   = cond_true(cond, flags_view);
  assign is_branch = (kind == kind_b) || (kind == kind_bl);

  // Word offset to signed byte displacement
  assign offset_sx = {{(`EXEC_DATA_W-`EXEC_OFFSET_W){offset[`EXEC_OFFSET_W-1]}}, offset}
                     << `EXEC_TARGET_SHIFT;
  assign target    = next_pc + offset_sx;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      taken_q <= 1'b0;
      link_q  <= 1'b0;
    end else begin
      taken_q <= is_branch && cond_ok;
      link_q  <= (kind == kind_bl) && cond_ok; // Link only on a taken BL
    end
  end

  always_ff @(posedge clk) begin
    target_q  <= target;
    link_pc_q <= next_pc; // Return address for BL
  end

  assign br = '{taken: taken_q, link: link_q, target: target_q};
  assign link_pc = link_pc_q;

endmodule

// File: hw/exec_commit.sv
// Result commit and status flags
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_commit
  import exec_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  exec_result_if.consumer         res,
  input  branch_t                 br,
  input  logic [`EXEC_DATA_W-1:0] link_pc,
  output flags_t                  flags_view,
  output logic                    out_valid,
  output logic [`EXEC_DATA_W-1:0] out_result,
  output logic                    out_taken,
  output logic                    out_link,
  output logic [`EXEC_DATA_W-1:0] out_target,
  output flags_t                  flags
);

  flags_t psr;
  logic   psr_we;

  assign psr_we = res.valid && res.store_cc;

  // Newest flags win, so a back-to-back branch sees them before the PSR does
  assign flags_view = psr_we ? res.flags : psr;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      psr       <= '0;
      out_valid <= 1'b0;
      out_taken <= 1'b0;
      out_link  <= 1'b0;
    end else begin
      if (psr_we) begin
        psr <= res.flags;
      end
      out_valid <= res.valid;
      out_taken <= res.valid && br.taken;
      out_link  <= res.valid && br.link;
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid) begin
      out_result <= br.link ? link_pc : res.result; // BL writes the return address
      out_target <= br.target;
    end
  end

  assign flags = psr; // PSR is already a register

endmodule

// File: hw/exec_stage.sv
// Execute stage top level
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_stage
  import exec_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  instr_kind_e               in_kind,
  input  alu_op_e                   in_alu_op,
  input  addr_mode_e                in_am,
  input  logic [`EXEC_IMM_W-1:0]    in_imm,
  input  logic [`EXEC_DATA_W-1:0]   in_rm,
  input  logic [`EXEC_DATA_W-1:0]   in_rn,
  input  logic                      in_store_cc,
  input  cond_e                     in_cond,
  input  logic [`EXEC_OFFSET_W-1:0] in_offset,
  input  logic [`EXEC_DATA_W-1:0]   in_next_pc,
  output logic                      out_valid,
  output logic [`EXEC_DATA_W-1:0]   out_result,
  output logic                      out_taken,
  output logic                      out_link,
  output logic [`EXEC_DATA_W-1:0]   out_target,
  output flags_t                    flags
);

  branch_t                 br;
  logic [`EXEC_DATA_W-1:0] link_pc;
  flags_t                  flags_view; // Forwarded flags for the condition test

  exec_result_if res_if ();

  operand_alu u_operand_alu (
    .clk      (clk),
    .reset    (reset),
    .valid    (in_valid),
    .alu_op   (in_alu_op),
    .am       (in_am),
    .imm      (in_imm),
    .rm       (in_rm),
    .rn       (in_rn),
    .store_cc (in_store_cc),
    .res      (res_if.producer)
  );

  branch_resolver u_branch_resolver (
    .clk        (clk),
    .reset      (reset),
    .kind       (in_kind),
    .cond       (in_cond),
    .offset     (in_offset),
    .next_pc    (in_next_pc),
    .flags_view (flags_view),
    .br         (br),
    .link_pc    (link_pc)
  );

  exec_commit u_exec_commit (
    .clk        (clk),
    .reset      (reset),
    .res        (res_if.consumer),
    .br         (br),
    .link_pc    (link_pc),
    .flags_view (flags_view),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_taken  (out_taken),
    .out_link   (out_link),
    .out_target (out_target),
    .flags      (flags)
  );

endmodule

// File: verification/tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

endmodule

// File: verification/exec_asserts.sv
// Execute stage checker
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_asserts
  import exec_pkg::*;
(
  input logic                      clk,
  input logic                      reset,
  input logic                      in_valid,
  input instr_kind_e               in_kind,
  input alu_op_e                   in_alu_op,
  input addr_mode_e                in_am,
  input logic [`EXEC_IMM_W-1:0]    in_imm,
  input logic [`EXEC_DATA_W-1:0]   in_rm,
  input logic [`EXEC_DATA_W-1:0]   in_rn,
  input logic                      in_store_cc,
  input cond_e                     in_cond,
  input logic [`EXEC_OFFSET_W-1:0] in_offset,
  input logic [`EXEC_DATA_W-1:0]   in_next_pc,
  input logic                      out_valid,
  input logic [`EXEC_DATA_W-1:0]   out_result,
  input logic                      out_taken,
  input logic                      out_link,
  input logic [`EXEC_DATA_W-1:0]   out_target,
  input flags_t                    flags
);

  localparam int dw  = `EXEC_DATA_W;
  localparam int lat = `EXEC_LATENCY;

  int err_count = 0; // Read by the testbench top

  flags_t                 psr_model; // Shadow PSR
  flags_t                 psr_next;
  logic [dw-1:0]          b_now;
  logic [dw+3:0]          alu_now;   // {flags, result}
  logic                   taken_now;
  logic                   link_now;
  logic signed [dw-1:0]   off_now;
  logic [lat-1:0]         exp_valid;
  logic [lat-1:0]         exp_taken;
  logic [lat-1:0]         exp_link;
  logic [lat-1:0][dw-1:0] exp_result;
  logic [lat-1:0][dw-1:0] exp_target;
  flags_t [lat-1:0]       exp_flags;

  function automatic logic [dw-1:0] rotate_right(input logic [dw-1:0] x, input int n);
    logic [dw-1:0] y;
    y = x;
    for (int i = 0; i < n; i++) begin
      y = {y[0], y[dw-1:1]};
    end
    return y;
  endfunction

  function automatic logic [dw-1:0] shift_arith(input logic [dw-1:0] x, input int n);
    logic [dw-1:0] y;
    y = x;
    for (int i = 0; i < n; i++) begin
      y = {y[dw-1], y[dw-1:1]}; // Sign bit copied in
    end
    return y;
  endfunction

  function automatic logic [dw-1:0] second_operand(input addr_mode_e am,
                                                   input logic [11:0] imm,
                                                   input logic [dw-1:0] rm);
    int amt;
    amt = imm[11:7];
    case (am)
      am_rot_imm:  return rotate_right(dw'(imm[7:0]), 2 * imm[11:8]);
      am_reg:      return rm;
      am_zext_imm: return dw'(imm);
      default: begin
        case (imm[6:5])
          2'b00:   return rm << amt;
          2'b01:   return rm >> amt;
          2'b10:   return shift_arith(rm, amt);
          default: return rotate_right(rm, amt);
        endcase
      end
    endcase
  endfunction

  function automatic logic [dw+3:0] alu_ref(input logic [3:0] op, input logic [dw-1:0] a,
                                            input logic [dw-1:0] b);
    logic [dw-1:0] y;
    logic [dw:0]   wide;
    longint        exact;
    flags_t        f;
    f = '0;
    y = '0;
    case (op)
      4'd0: y = a & b;
      4'd1: y = a | b;
      4'd2: begin
        wide  = {1'b0, a} - {1'b0, b};
        y     = wide[dw-1:0];
        f.c   = ~wide[dw]; // No borrow out
        exact = longint'($signed(a)) - longint'($signed(b));
        f.v   = (exact != longint'($signed(y))); // Exact result lost in 32 bits
      end
      4'd3: begin
        wide  = a + b;
        y     = wide[dw-1:0];
        f.c   = wide[dw];
        exact = longint'($signed(a)) + longint'($signed(b));
        f.v   = (exact != longint'($signed(y)));
      end
      default: y = '0;
    endcase
    f.n = y[dw-1];
    f.z = (y == '0);
    return {f, y};
  endfunction

  // Odd codes invert the test of the even code below them
  function automatic logic cond_holds(input logic [3:0] c, input flags_t f);
    logic base;
    case (c[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.n;
      3'd3: base = f.v;
      3'd4: base = f.c & ~f.z;
      3'd5: base = (f.n == f.v);
      3'd6: base = ~f.z & (f.n == f.v);
      default: return (c == 4'he); // 1111 never
    endcase
    return base ^ c[0];
  endfunction

  always_comb begin
    b_now     = second_operand(in_am, in_imm, in_rm);
    alu_now   = alu_ref(in_alu_op, in_rn, b_now);
    taken_now = ((in_kind == kind_b) || (in_kind == kind_bl)) && cond_holds(in_cond, psr_model);
    link_now  = taken_now && (in_kind == kind_bl);
    off_now   = $signed(in_offset);
    psr_next  = (in_valid && in_store_cc) ? flags_t'(alu_now[dw+3:dw]) : psr_model;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      psr_model  <= '0;
      exp_valid  <= '0;
      exp_taken  <= '0;
      exp_link   <= '0;
      exp_result <= '0;
      exp_target <= '0;
      exp_flags  <= '0;
    end else begin
      psr_model  <= psr_next;
      exp_valid  <= {exp_valid[lat-2:0], in_valid};
      exp_taken  <= {exp_taken[lat-2:0], in_valid && taken_now};
      exp_link   <= {exp_link[lat-2:0], in_valid && link_now};
      exp_result <= {exp_result[lat-2:0], link_now ? in_next_pc : alu_now[dw-1:0]};
      exp_target <= {exp_target[lat-2:0], in_next_pc + off_now * (1 << `EXEC_TARGET_SHIFT)};
      exp_flags  <= {exp_flags[lat-2:0], psr_next};
    end
  end

  reset_state: assert property (@(posedge clk) reset |=> (!out_valid && !out_taken && flags == '0))
    else begin
      err_count++;
      $error("error: time %0t, outputs not cleared by reset", $time);
    end

  latency: assert property (@(posedge clk) disable iff (reset) out_valid == exp_valid[lat-1])
    else begin
      err_count++;
      $error("error: time %0t, out_valid not %0d cycles after in_valid", $time, lat);
    end

  result_value: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> out_result == exp_result[lat-1])
    else begin
      err_count++;
      $error("error: time %0t, out_result %h, model %h", $time, out_result, exp_result[lat-1]);
    end

  target_value: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> out_target == exp_target[lat-1])
    else begin
      err_count++;
      $error("error: time %0t, out_target %h, model %h", $time, out_target, exp_target[lat-1]);
    end

  taken_value: assert property (@(posedge clk) disable iff (reset) out_taken == exp_taken[lat-1])
    else begin
      err_count++;
      $error("error: time %0t, out_taken %b, model %b", $time, out_taken, exp_taken[lat-1]);
    end

  link_value: assert property (@(posedge clk) disable iff (reset) out_link == exp_link[lat-1])
    else begin
      err_count++;
      $error("error: time %0t, out_link %b, model %b", $time, out_link, exp_link[lat-1]);
    end

  flags_value: assert property (@(posedge clk) disable iff (reset) flags == exp_flags[lat-1])
    else begin
      err_count++;
      $error("error: time %0t, flags %b, model %b", $time, flags, exp_flags[lat-1]);
    end

endmodule

// File: verification/exec_tb.sv
// Execute stage testbench
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_tb
  import exec_pkg::*;
();

  localparam int seed        = 88227;
  localparam int reset_len   = 4;
  localparam int random_runs = 300;
  localparam int max_gap     = 2;
  localparam int directed_n  = 500; // Directed instructions and idle cycles, rounded up
  localparam int cycle_limit = reset_len + directed_n + random_runs * (1 + max_gap) + 40;

  localparam int shift_amts [3] = '{0, 31, 7};

  // Flag setters: add overflow, add carry to zero, sub overflow, sub borrow, sub equal
  localparam logic [3:0]              flag_op [5] = '{4'd3, 4'd3, 4'd2, 4'd2, 4'd2};
  localparam logic [`EXEC_DATA_W-1:0] flag_rn [5] = '{32'h7fff_ffff, 32'hffff_ffff,
                                                      32'h8000_0000, 32'h0, 32'h5};
  localparam logic [`EXEC_DATA_W-1:0] flag_rm [5] = '{32'h1, 32'h1, 32'h1, 32'h1, 32'h5};

  logic                      clk;
  logic                      reset;
  logic                      in_valid;
  instr_kind_e               in_kind;
  alu_op_e                   in_alu_op;
  addr_mode_e                in_am;
  logic [`EXEC_IMM_W-1:0]    in_imm;
  logic [`EXEC_DATA_W-1:0]   in_rm;
  logic [`EXEC_DATA_W-1:0]   in_rn;
  logic                      in_store_cc;
  cond_e                     in_cond;
  logic [`EXEC_OFFSET_W-1:0] in_offset;
  logic [`EXEC_DATA_W-1:0]   in_next_pc;
  logic                      out_valid;
  logic [`EXEC_DATA_W-1:0]   out_result;
  logic                      out_taken;
  logic                      out_link;
  logic [`EXEC_DATA_W-1:0]   out_target;
  flags_t                    flags;

  int issued      = 0;
  int completed   = 0;
  int cycles      = 0;
  int errors_seen = 0;
  int errors;

  tb_clock u_clock (.clk(clk));

  exec_stage uut (.*);

  bind exec_stage exec_asserts u_exec_asserts (.*);

  task automatic issue_instr(input instr_kind_e kind, input logic [3:0] op, input addr_mode_e am,
                             input logic [11:0] imm, input logic [31:0] rm, input logic [31:0] rn,
                             input logic store_cc, input logic [3:0] cond,
                             input logic [23:0] offset, input logic [31:0] next_pc);
    @(posedge clk);
    #10;
    in_valid    = 1'b1;
    in_kind     = kind;
    in_alu_op   = alu_op_e'(op);
    in_am       = am;
    in_imm      = imm;
    in_rm       = rm;
    in_rn       = rn;
    in_store_cc = store_cc;
    in_cond     = cond_e'(cond);
    in_offset   = offset;
    in_next_pc  = next_pc;
    issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
      in_valid = 1'b0;
    end
  endtask

  task automatic alu_mode_sweep();
    logic [11:0] imm;
    for (int op = 0; op < 4; op++) begin
      issue_instr(kind_alu, 4'(op), am_rot_imm, 12'h0a5, $urandom, $urandom, 1'b1, 4'he, '0, '0);
      issue_instr(kind_alu, 4'(op), am_rot_imm, {4'hf, 8'($urandom)}, $urandom, $urandom,
                  1'b1, 4'he, '0, '0);
      issue_instr(kind_alu, 4'(op), am_reg, 12'($urandom), $urandom, $urandom, 1'b1, 4'he, '0, '0);
      issue_instr(kind_alu, 4'(op), am_zext_imm, 12'($urandom), $urandom, $urandom,
                  1'b1, 4'he, '0, '0);
      for (int sh = 0; sh < 4; sh++) begin
        foreach (shift_amts[i]) begin
          imm = {5'(shift_amts[i]), 2'(sh), 5'($urandom)};
          issue_instr(kind_alu, 4'(op), am_shift_reg, imm, $urandom, $urandom,
                      1'($urandom), 4'he, '0, '0);
        end
      end
    end
  endtask

  // Flag setter then a branch, back to back or with one idle cycle between
  task automatic condition_sweep();
    for (int gap = 0; gap < 2; gap++) begin
      for (int p = 0; p < 5; p++) begin
        for (int c = 0; c < 16; c++) begin
          issue_instr(kind_alu, flag_op[p], am_reg, '0, flag_rm[p], flag_rn[p], 1'b1, 4'he,
                      '0, '0);
          idle_cycles(gap);
          issue_instr(c[0] ? kind_bl : kind_b, 4'd0, am_reg, '0, $urandom, $urandom, 1'b0,
                      4'(c), 24'($urandom), $urandom);
        end
        idle_cycles(1);
      end
    end
  endtask

  task automatic branch_cases();
    issue_instr(kind_bl, 4'd3, am_reg, '0, $urandom, $urandom, 1'b0, 4'he, 24'h00_0010,
                32'h0000_2000);
    issue_instr(kind_b, 4'd3, am_reg, '0, $urandom, $urandom, 1'b0, 4'he, 24'hff_fff0,
                32'h0000_2000);
    issue_instr(kind_bl, 4'd3, am_reg, '0, $urandom, $urandom, 1'b0, 4'he, 24'h80_0000,
                32'h0100_0000); // Most negative offset
    issue_instr(kind_bl, 4'd3, am_reg, '0, $urandom, $urandom, 1'b0, 4'hf, 24'h7f_ffff,
                32'h0000_4000);
    issue_instr(kind_b, 4'd3, am_reg, '0, $urandom, $urandom, 1'b0, 4'hf, 24'h00_0001,
                32'h0000_4000);
    idle_cycles(2);
  endtask

  task automatic random_traffic();
    repeat (random_runs) begin
      issue_instr(instr_kind_e'($urandom_range(0, 2)), 4'($urandom_range(0, 5)),
                  addr_mode_e'($urandom_range(0, 3)), 12'($urandom), $urandom, $urandom,
                  1'($urandom), 4'($urandom), 24'($urandom), $urandom);
      if ($urandom_range(0, 3) == 0) begin
        idle_cycles($urandom_range(1, max_gap));
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset && out_valid) begin
      completed++;
    end
    if (uut.u_exec_asserts.err_count != errors_seen) begin
      errors_seen = uut.u_exec_asserts.err_count;
      $display("error: time %0t, %0d checker failures so far", $time, errors_seen);
    end
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_kind     = kind_alu;
    in_alu_op   = op_add;
    in_am       = am_reg;
    in_imm      = '0;
    in_rm       = '0;
    in_rn       = '0;
    in_store_cc = 1'b0;
    in_cond     = cond_al;
    in_offset   = '0;
    in_next_pc  = '0;
    void'($urandom(seed));
    repeat (reset_len) @(posedge clk);
    #10;
    reset = 1'b0;
    alu_mode_sweep();
    condition_sweep();
    branch_cases();
    random_traffic();
    idle_cycles(1);
    wait (completed == issued);
    repeat (`EXEC_LATENCY) @(posedge clk); // Last results reach the checker
    errors = uut.u_exec_asserts.err_count;
    $display("summary: %0d issued, %0d completed, %0d assertion failures",
             issued, completed, errors);
    if (errors == 0 && completed == issued) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
hw/exec_pkg.sv
hw/exec_result_if.sv
hw/operand_alu.sv
hw/branch_resolver.sv
hw/exec_commit.sv
hw/exec_stage.sv
verification/tb_clock.sv
verification/exec_asserts.sv
verification/exec_tb.sv

// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/exec_pkg.sv
      - hw/exec_result_if.sv
      - hw/operand_alu.sv
      - hw/branch_resolver.sv
      - hw/exec_commit.sv
      - hw/exec_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock.sv
      - verification/exec_asserts.sv
      - verification/exec_tb.sv
